// File: include/beat_bridge_params.svh
// Shared sizing macros for the beat bridge; include wherever a width or depth is needed

`ifndef BEAT_BRIDGE_PARAMS_SVH
`define BEAT_BRIDGE_PARAMS_SVH

// ========================================
// Data path widths
// ========================================

// Width of the data field carried by each beat
`define BB_DATA_W 32

// ========================================
// Buffer depths
// ========================================

// Entries in the source FIFO ahead of the bridge
`define BB_SRC_DEPTH 16

// Entries in the bridge skid buffer
// Four slots cover the read in flight plus consumer stalls
`define BB_SKID_DEPTH 4

// Entries in the consumer summary queue
`define BB_SUM_DEPTH 2

`endif

// File: rtl/beat_bridge_pkg.sv
// Common types for the beat bridge data path; compile first, import where the types are used

`include "beat_bridge_params.svh"

package beat_bridge_pkg;

        // ========================================
        // Stream payloads
        // ========================================

        // One beat of a packet
        // last marks the final beat of the packet
        typedef struct packed {
                logic [`BB_DATA_W-1:0] data;
                logic                  last;
        } beat_t;

        // Per packet summary built by the consumer
        // Beat count wraps modulo 256
        // Sum is the modular sum of all data words
        typedef struct packed {
                logic [7:0]  beats;
                logic [31:0] sum;
        } pkt_sum_t;

        // ========================================
        // Status
        // ========================================

        // Skid buffer fill level, 0 up to BB_SKID_DEPTH inclusive
        typedef logic [$clog2(`BB_SKID_DEPTH + 1)-1:0] skid_occ_t;

endpackage

// File: rtl/skid_fifo.sv
// Small synchronous FIFO with a combinational read port; payload type set per instance

module skid_fifo #(
        parameter int  DEPTH     = 4,
        parameter type payload_t = logic [7:0]
) (
        input  logic                         clk,
        input  logic                         rst,
        input  logic                         wr_valid,
        input  payload_t                     wr_data,
        input  logic                         rd_ready,
        output logic                         wr_ready,
        output logic                         rd_valid,
        output payload_t                     rd_data,
        output logic [$clog2(DEPTH + 1)-1:0] count
);

        // Pointer needs at least one bit even for a single entry
        localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
        localparam int CNT_W = $clog2(DEPTH + 1);

        // ========================================
        // Storage
        // ========================================

        payload_t         mem [DEPTH];
        logic [PTR_W-1:0] wr_ptr;
        logic [PTR_W-1:0] rd_ptr;

        logic             wr_fire;
        logic             rd_fire;

        // Room only below DEPTH
        // A pop in the same cycle does not open a slot early
        assign wr_ready = (count < CNT_W'(DEPTH));
        assign rd_valid = (count != '0);

        assign wr_fire = wr_valid && wr_ready;
        assign rd_fire = rd_valid && rd_ready;

        // Head is read straight from memory, no output register
        assign rd_data = mem[rd_ptr];

        always_ff @(posedge clk) begin
                if (wr_fire) begin
                        mem[wr_ptr] <= wr_data;
                end
        end

        // ========================================
        // Pointer and count control
        // ========================================

        always_ff @(posedge clk) begin
                if (rst) begin
                        wr_ptr <= '0;
                        rd_ptr <= '0;
                end else begin
                        // Wrap by compare so odd depths work too
                        if (wr_fire) begin
                                if (wr_ptr == PTR_W'(DEPTH - 1)) begin
                                        wr_ptr <= '0;
                                end else begin
                                        wr_ptr <= wr_ptr + 1'b1;
                                end
                        end
                        if (rd_fire) begin
                                if (rd_ptr == PTR_W'(DEPTH - 1)) begin
                                        rd_ptr <= '0;
                                end else begin
                                        rd_ptr <= rd_ptr + 1'b1;
                                end
                        end
                end
        end

        // Entry count, also exported as fill level
        always_ff @(posedge clk) begin
                if (rst) begin
                        count <= '0;
                end else begin
                        case ({wr_fire, rd_fire})
                                2'b10:   count <= count + 1'b1;
                                2'b01:   count <= count - 1'b1;
                                default: count <= count;
                        endcase
                end
        end

endmodule

// File: rtl/beat_src_fifo.sv
// Source FIFO with a valid/ready write port and a one-cycle-latency registered read port

`include "beat_bridge_params.svh"

module beat_src_fifo (
        input  logic                     clk,
        input  logic                     rst,
        input  logic                     in_valid,
        input  beat_bridge_pkg::beat_t   in_beat,
        input  logic                     rd_req,
        output logic                     in_ready,
        output logic                     src_avail,
        output beat_bridge_pkg::beat_t   src_beat
);

        import beat_bridge_pkg::*;

        localparam int DEPTH = `BB_SRC_DEPTH;
        localparam int PTR_W = $clog2(DEPTH);
        localparam int CNT_W = $clog2(DEPTH + 1);

        // ========================================
        // Storage and pointers
        // ========================================

        beat_t            mem [DEPTH];
        logic [PTR_W-1:0] wr_ptr;
        logic [PTR_W-1:0] rd_ptr;
        logic [CNT_W-1:0] count;

        logic             wr_fire;
        logic             rd_fire;

        // Write side accepts whenever a slot is free
        assign in_ready  = (count != CNT_W'(DEPTH));
        assign src_avail = (count != '0);

        assign wr_fire = in_valid && in_ready;
        // Strobe is qualified again so an empty FIFO is never popped
        assign rd_fire = rd_req && src_avail;

        // Beat lands in memory at the accepting edge
        always_ff @(posedge clk) begin
                if (wr_fire) begin
                        mem[wr_ptr] <= in_beat;
                end
        end

        // Registered read port
        // Value holds until the edge after the next strobe
        always_ff @(posedge clk) begin
                if (rd_fire) begin
                        src_beat <= mem[rd_ptr];
                end
        end

        // ========================================
        // Pointer and count control
        // ========================================

        always_ff @(posedge clk) begin
                if (rst) begin
                        wr_ptr <= '0;
                        rd_ptr <= '0;
                        count  <= '0;
                end else begin
                        if (wr_fire) begin
                                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
                        end
                        if (rd_fire) begin
                                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
                        end
                        // Simultaneous push and pop leave the count alone
                        case ({wr_fire, rd_fire})
                                2'b10:   count <= count + 1'b1;
                                2'b01:   count <= count - 1'b1;
                                default: count <= count;
                        endcase
                end
        end

endmodule

// File: rtl/latency_bridge.sv
// Bridge from a latency-1 FIFO read port to a valid/ready stream through a skid buffer

`include "beat_bridge_params.svh"

module latency_bridge (
        input  logic                       clk,
        input  logic                       rst,
        input  logic                       src_avail,
        input  beat_bridge_pkg::beat_t     src_beat,
        input  logic                       br_ready,
        output logic                       rd_req,
        output logic                       br_valid,
        output beat_bridge_pkg::beat_t     br_beat,
        output beat_bridge_pkg::skid_occ_t occupancy
);

        import beat_bridge_pkg::*;

        // ========================================
        // Read in flight tracking
        // ========================================

        // Set the cycle after a read strobe, when src_beat carries the beat
        logic      in_flight;

        logic      skid_wr_valid;
        logic      skid_wr_ready;
        logic      write_stalled;
        logic      draining;
        skid_occ_t pending;
        logic      room;
        logic      rd_ready;

        assign skid_wr_valid = in_flight;

        // Arriving beat could not land because the skid is full
        assign write_stalled = skid_wr_valid && !skid_wr_ready;
        // Consumer takes a beat this cycle
        assign draining = br_valid && br_ready;

        // Stalled beat already owns a slot
        assign pending = occupancy + skid_occ_t'(write_stalled);
        assign room    = (pending < skid_occ_t'(`BB_SKID_DEPTH));

        // A beat leaving frees a slot for the next read
        // Never while a stalled beat still waits on src_beat
        assign rd_ready = room || (draining && !write_stalled);
        assign rd_req   = src_avail && rd_ready;

        // Flag holds through a stall so the beat is written once room opens
        // src_beat stays put since no new read goes out meanwhile
        always_ff @(posedge clk) begin
                if (rst) begin
                        in_flight <= 1'b0;
                end else begin
                        in_flight <= rd_req || write_stalled;
                end
        end

        // ========================================
        // Skid buffer
        // ========================================

        skid_fifo #(
                .DEPTH     (`BB_SKID_DEPTH),
                .payload_t (beat_t)
        ) i_skid_fifo (
                .clk      (clk),
                .rst      (rst),
                .wr_valid (skid_wr_valid),
                .wr_data  (src_beat),
                .rd_ready (br_ready),
                .wr_ready (skid_wr_ready),
                .rd_valid (br_valid),
                .rd_data  (br_beat),
                .count    (occupancy)
        );

endmodule

// File: rtl/pkt_checksum.sv
// Packet consumer that folds beats into count and sum summaries and queues them out

`include "beat_bridge_params.svh"

module pkt_checksum (
        input  logic                      clk,
        input  logic                      rst,
        input  logic                      br_valid,
        input  beat_bridge_pkg::beat_t    br_beat,
        input  logic                      out_ready,
        output logic                      br_ready,
        output logic                      out_valid,
        output beat_bridge_pkg::pkt_sum_t out_sum
);

        import beat_bridge_pkg::*;

        // ========================================
        // Accumulator
        // ========================================

        // Running count and sum of the packet being received
        pkt_sum_t acc;
        // Summary including the beat on the input this cycle
        pkt_sum_t acc_next;

        logic     sum_wr_valid;
        logic     sum_wr_ready;
        logic     beat_fire;

        // Only take beats while a summary write can be accepted
        // So the last beat never has to wait on the queue
        assign br_ready  = sum_wr_ready;
        assign beat_fire = br_valid && br_ready;

        // Both fields wrap naturally at their widths
        assign acc_next.beats = acc.beats + 8'd1;
        assign acc_next.sum   = acc.sum + 32'(br_beat.data);

        // Summary written at the edge that accepts the last beat
        assign sum_wr_valid = beat_fire && br_beat.last;

        always_ff @(posedge clk) begin
                if (rst) begin
                        acc <= '0;
                end else if (beat_fire) begin
                        if (br_beat.last) begin
                                // Start fresh for the next packet
                                acc <= '0;
                        end else begin
                                acc <= acc_next;
                        end
                end
        end

        // ========================================
        // Summary queue
        // ========================================

        // Fill level is not needed here
        skid_fifo #(
                .DEPTH     (`BB_SUM_DEPTH),
                .payload_t (pkt_sum_t)
        ) i_sum_fifo (
                .clk      (clk),
                .rst      (rst),
                .wr_valid (sum_wr_valid),
                .wr_data  (acc_next),
                .rd_ready (out_ready),
                .wr_ready (sum_wr_ready),
                .rd_valid (out_valid),
                .rd_data  (out_sum),
                .count    ()
        );

endmodule

// File: rtl/beat_bridge_top.sv
// Top level of the beat bridge: source FIFO, latency bridge and packet checksum in series

module beat_bridge_top (
        input  logic                       clk,
        input  logic                       rst,
        input  logic                       in_valid,
        input  beat_bridge_pkg::beat_t     in_beat,
        input  logic                       out_ready,
        output logic                       in_ready,
        output logic                       out_valid,
        output beat_bridge_pkg::pkt_sum_t  out_sum,
        output beat_bridge_pkg::skid_occ_t occupancy
);

        import beat_bridge_pkg::*;

        // ========================================
        // Internal links
        // ========================================

        // Source to bridge, strobe plus one cycle of latency
        logic  rd_req;
        logic  src_avail;
        beat_t src_beat;

        // Bridge to consumer, valid/ready
        logic  br_valid;
        logic  br_ready;
        beat_t br_beat;

        // Producer side
        beat_src_fifo i_beat_src_fifo (
                .clk       (clk),
                .rst       (rst),
                .in_valid  (in_valid),
                .in_beat   (in_beat),
                .rd_req    (rd_req),
                .in_ready  (in_ready),
                .src_avail (src_avail),
                .src_beat  (src_beat)
        );

        // Read tracking and skid buffering
        latency_bridge i_latency_bridge (
                .clk       (clk),
                .rst       (rst),
                .src_avail (src_avail),
                .src_beat  (src_beat),
                .br_ready  (br_ready),
                .rd_req    (rd_req),
                .br_valid  (br_valid),
                .br_beat   (br_beat),
                .occupancy (occupancy)
        );

        // Per packet summaries toward the outside
        pkt_checksum i_pkt_checksum (
                .clk       (clk),
                .rst       (rst),
                .br_valid  (br_valid),
                .br_beat   (br_beat),
                .out_ready (out_ready),
                .br_ready  (br_ready),
                .out_valid (out_valid),
                .out_sum   (out_sum)
        );

endmodule

// File: tb/beat_bridge_tb.sv
// Self-checking testbench for the beat bridge; drives packets in and checks every summary out

`include "beat_bridge_params.svh"

module beat_bridge_tb;

        import beat_bridge_pkg::*;

        // Cycle limit for every wait loop
        localparam int WAIT_LIMIT  = 2000;
        // Packets offered at most while filling the stalled path
        localparam int STALL_LIMIT = 50;

        logic       clk;
        logic       rst;
        logic       in_valid;
        beat_t      in_beat;
        logic       out_ready;
        logic       in_ready;
        logic       out_valid;
        pkt_sum_t   out_sum;
        skid_occ_t  occupancy;

        integer     seed = 94;
        string      test_name;
        int         value_errors;
        int         other_errors;
        int         pkt_count;
        int         sum_count;
        bit         gap_en;
        bit         toggle_ready;

        // Data words of the packet being sent
        // Up to 12 beats
        logic [`BB_DATA_W-1:0] pkt_data [12];
        int         pkt_len;
        // Expected summaries in send order
        pkt_sum_t   exp_q [$];

        beat_bridge_top i_beat_bridge_top (
                .clk       (clk),
                .rst       (rst),
                .in_valid  (in_valid),
                .in_beat   (in_beat),
                .out_ready (out_ready),
                .in_ready  (in_ready),
                .out_valid (out_valid),
                .out_sum   (out_sum),
                .occupancy (occupancy)
        );

        always #4 clk = ~clk;

        // ========================================
        // Compare tasks and reference model
        // ========================================

        task automatic check_sum(input string name, input pkt_sum_t exp, input pkt_sum_t act);
                if (exp !== act) begin
                        $display("error %s expected beats=%0d sum=%h actual beats=%0d sum=%h",
                                 name, exp.beats, exp.sum, act.beats, act.sum);
                        value_errors++;
                end
        endtask

        task automatic check_occ(input string name, input skid_occ_t exp, input skid_occ_t act);
                if (exp !== act) begin
                        $display("error %s expected occupancy=%0d actual occupancy=%0d",
                                 name, exp, act);
                        value_errors++;
                end
        endtask

        task automatic check_bit(input string name, input logic exp, input logic act);
                if (exp !== act) begin
                        $display("error %s expected %b actual %b", name, exp, act);
                        value_errors++;
                end
        endtask

        task automatic check_count(input string name, input int exp, input int act);
                if (exp != act) begin
                        $display("error %s expected %0d actual %0d", name, exp, act);
                        value_errors++;
                end
        endtask

        // Beat count and modular data sum of the first n words
        function automatic pkt_sum_t fold_packet(input int n);
                pkt_sum_t s;
                int       i;
                s = '0;
                for (i = 0; i < n; i++) begin
                        s.beats = s.beats + 8'd1;
                        s.sum   = s.sum + 32'(pkt_data[i]);
                end
                return s;
        endfunction

        function automatic beat_t beat_at(input int i);
                beat_t b;
                b.data = pkt_data[i];
                b.last = (i == pkt_len - 1);
                return b;
        endfunction

        // ========================================
        // Stimulus helpers
        // ========================================

        // All inputs change on the falling edge
        task automatic next_cycle();
                @(negedge clk);
                if (toggle_ready) begin
                        out_ready = $random(seed) & 1;
                end
        endtask

        task automatic make_packet(input int len);
                int i;
                pkt_len = len;
                for (i = 0; i < len; i++) begin
                        pkt_data[i] = $random(seed);
                end
                exp_q.push_back(fold_packet(len));
                pkt_count++;
        endtask

        task automatic send_beat(input beat_t b);
                int waited;
                bit accepted;
                // Idle cycles ahead of the beat about half the time
                while (gap_en && ($random(seed) & 1)) begin
                        next_cycle();
                end
                in_valid = 1'b1;
                in_beat  = b;
                accepted = 1'b0;
                waited   = 0;
                while (!accepted && waited < WAIT_LIMIT) begin
                        @(posedge clk);
                        accepted = in_ready;
                        waited++;
                        next_cycle();
                end
                in_valid = 1'b0;
                if (!accepted) begin
                        $display("timeout: input stream never accepted a beat in %s", test_name);
                        other_errors++;
                end
        endtask

        // Beat offered for a single edge only
        // Caller keeps a rejected beat
        task automatic offer_once(input beat_t b, output bit accepted);
                in_valid = 1'b1;
                in_beat  = b;
                @(posedge clk);
                accepted = in_ready;
                next_cycle();
                in_valid = 1'b0;
        endtask

        task automatic send_packet(input int len);
                int i;
                make_packet(len);
                for (i = 0; i < len; i++) begin
                        send_beat(beat_at(i));
                end
        endtask

        task automatic wait_drain();
                int waited;
                waited = 0;
                while (exp_q.size() != 0 && waited < WAIT_LIMIT) begin
                        next_cycle();
                        waited++;
                end
                if (exp_q.size() != 0) begin
                        $display("timeout: %0d summaries never came out in %s",
                                 exp_q.size(), test_name);
                        other_errors++;
                end
        endtask

        // ========================================
        // Output monitor
        // ========================================

        always @(posedge clk) begin
                pkt_sum_t exp;
                if (!rst) begin
                        if (occupancy > skid_occ_t'(`BB_SKID_DEPTH)) begin
                                $display("skid occupancy %0d went above its depth in %s",
                                         occupancy, test_name);
                                other_errors++;
                        end
                        if (out_valid && out_ready) begin
                                sum_count++;
                                if (exp_q.size() == 0) begin
                                        $display("summary came out with no packet pending in %s",
                                                 test_name);
                                        other_errors++;
                                end else begin
                                        exp = exp_q.pop_front();
                                        check_sum(test_name, exp, out_sum);
                                end
                        end
                end
        end

        // ========================================
        // Test sequence
        // ========================================

        initial begin
                int  i;
                int  idx;
                int  guard;
                bit  full;
                bit  acc;
                clk          = 1'b0;
                rst          = 1'b1;
                in_valid     = 1'b0;
                in_beat      = '0;
                out_ready    = 1'b0;
                gap_en       = 1'b0;
                toggle_ready = 1'b0;
                value_errors = 0;
                other_errors = 0;
                pkt_count    = 0;
                sum_count    = 0;
                test_name    = "reset";
                repeat (5) @(posedge clk);
                @(negedge clk);
                rst = 1'b0;

                check_bit("reset in_ready", 1'b1, in_ready);
                check_bit("reset out_valid", 1'b0, out_valid);
                check_occ("reset occupancy", '0, occupancy);
                out_ready = 1'b1;

                // Summary of one beat is that beat alone
                test_name = "single_beat";
                make_packet(1);
                send_beat(beat_at(0));
                wait_drain();
                check_count("single_beat summaries", 1, sum_count);

                test_name = "back_to_back";
                for (i = 0; i < 20; i++) begin
                        send_packet(($unsigned($random(seed)) % 12) + 1);
                end
                wait_drain();
                check_count("back_to_back summaries", pkt_count, sum_count);

                // Random gaps and random consumer back-pressure
                test_name    = "random_flow";
                gap_en       = 1'b1;
                toggle_ready = 1'b1;
                for (i = 0; i < 30; i++) begin
                        send_packet(($unsigned($random(seed)) % 12) + 1);
                end
                toggle_ready = 1'b0;
                gap_en       = 1'b0;
                out_ready    = 1'b1;
                wait_drain();
                check_count("random_flow summaries", pkt_count, sum_count);

                // Consumer stalled until the input side fills
                test_name = "stall_fill";
                out_ready = 1'b0;
                full      = 1'b0;
                guard     = 0;
                idx       = 0;
                while (!full && guard < STALL_LIMIT) begin
                        make_packet(($unsigned($random(seed)) % 12) + 1);
                        idx = 0;
                        while (idx < pkt_len && !full) begin
                                offer_once(beat_at(idx), acc);
                                if (acc) begin
                                        idx++;
                                end else begin
                                        full = 1'b1;
                                end
                        end
                        guard++;
                end
                if (!full) begin
                        $display("in_ready never fell with the consumer stalled");
                        other_errors++;
                end
                check_occ("stall_fill occupancy", skid_occ_t'(`BB_SKID_DEPTH), occupancy);
                out_ready = 1'b1;
                // Rest of the packet cut off by the stall
                while (idx < pkt_len) begin
                        send_beat(beat_at(idx));
                        idx++;
                end
                wait_drain();

                test_name = "drained";
                check_occ("drained occupancy", '0, occupancy);
                check_bit("drained out_valid", 1'b0, out_valid);
                check_count("total summaries", pkt_count, sum_count);

                $display("checks done: %0d value errors, %0d other failures",
                         value_errors, other_errors);
                if (value_errors == 0 && other_errors == 0) begin
                        $display("STATUS: PASS");
                end else begin
                        $display("STATUS: FAIL");
                end
                $finish;
        end

endmodule

// File: beat_bridge.f
+incdir+include
rtl/beat_bridge_pkg.sv
rtl/skid_fifo.sv
rtl/beat_src_fifo.sv
rtl/latency_bridge.sv
rtl/pkt_checksum.sv
rtl/beat_bridge_top.sv
tb/beat_bridge_tb.sv
